//--- rtl/rv_decode_pkg.sv
// RV32I decode definitions
`default_nettype none

package rv_decode_pkg;

    //----------------------------------------------------------------------
    // widths and types
    //----------------------------------------------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     ins_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      aluop_t;
    typedef logic [1:0]      zone_t;
    typedef logic [2:0]      imm_type_t;

    //----------------------------------------------------------------------
    // major opcodes
    //----------------------------------------------------------------------
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_AUIPC   = 7'b0010111;
    localparam opcode_t OPC_JAL     = 7'b1101111;
    localparam opcode_t OPC_JALR    = 7'b1100111;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_OPIMM   = 7'b0010011;
    localparam opcode_t OPC_OP      = 7'b0110011;
    localparam opcode_t OPC_MISCMEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM  = 7'b1110011;

    // minor opcodes for OP and OP-IMM
    localparam funct3_t F3_ADDSUB = 3'b000;
    localparam funct3_t F3_SLL    = 3'b001;
    localparam funct3_t F3_SLT    = 3'b010;
    localparam funct3_t F3_SLTU   = 3'b011;
    localparam funct3_t F3_XOR    = 3'b100;
    localparam funct3_t F3_SRLSRA = 3'b101;
    localparam funct3_t F3_OR     = 3'b110;
    localparam funct3_t F3_AND    = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub / sra

    //----------------------------------------------------------------------
    // ALU operations
    //----------------------------------------------------------------------
    localparam aluop_t ALUOP_ADD  = 4'd0;
    localparam aluop_t ALUOP_SUB  = 4'd1;
    localparam aluop_t ALUOP_SLL  = 4'd2;
    localparam aluop_t ALUOP_SLT  = 4'd3;
    localparam aluop_t ALUOP_SLTU = 4'd4;
    localparam aluop_t ALUOP_XOR  = 4'd5;
    localparam aluop_t ALUOP_SRL  = 4'd6;
    localparam aluop_t ALUOP_SRA  = 4'd7;
    localparam aluop_t ALUOP_OR   = 4'd8;
    localparam aluop_t ALUOP_AND  = 4'd9;
    localparam aluop_t ALUOP_MOV  = 4'd10;  // pass operand 2

    // destination zones
    localparam zone_t ZONE_NONE    = 2'd0;
    localparam zone_t ZONE_REGFILE = 2'd1;
    localparam zone_t ZONE_LOADQ   = 2'd2;
    localparam zone_t ZONE_STOREQ  = 2'd3;

    // immediate formats, code 2 unused
    localparam imm_type_t IMM_R        = 3'd0;
    localparam imm_type_t IMM_I        = 3'd1;
    localparam imm_type_t IMM_S        = 3'd3;
    localparam imm_type_t IMM_SB       = 3'd4;
    localparam imm_type_t IMM_U        = 3'd5;
    localparam imm_type_t IMM_UJ       = 3'd6;
    localparam imm_type_t IMM_MISC_MEM = 3'd7;

endpackage

`default_nettype wire

//--- rtl/ins_fields_if.sv
// Instruction field bundle
`timescale 1ns/10ps
`default_nettype none

interface ins_fields_if;
    import rv_decode_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    reg_addr_t rs1;
    ins_t      ins;      // whole word, for immediates and system

    // slicing side
    modport src (output opcode, funct3, funct7, rd, rs1, ins);

    // decoder side
    modport dec (input opcode, funct3, funct7, rd, rs1, ins);

endinterface

`default_nettype wire

//--- rtl/rv_alu_decode.sv
// ALU operation decode
`timescale 1ns/10ps
`default_nettype none

module rv_alu_decode (
    ins_fields_if.dec              fields,
    input  wire                    reg_form_i,      // OP, else OP-IMM
    output rv_decode_pkg::aluop_t  aluop_o,
    output logic                   selcmps2_imm_o,
    output logic                   illegal_o
);
    import rv_decode_pkg::*;

    logic f7_base;
    logic f7_alt;

    assign f7_base = (fields.funct7 == F7_BASE);
    assign f7_alt  = (fields.funct7 == F7_ALT);

    always_comb begin
        aluop_o        = ALUOP_ADD;
        selcmps2_imm_o = 1'b0;
        illegal_o      = 1'b0;

        case (fields.funct3)
            F3_ADDSUB: begin
                if (reg_form_i && f7_alt) begin
                    aluop_o = ALUOP_SUB;
                end
            end
            F3_SLL:  aluop_o = ALUOP_SLL;
            F3_SLT: begin
                aluop_o        = ALUOP_SLT;
                selcmps2_imm_o = !reg_form_i;
            end
            F3_SLTU: begin
                aluop_o        = ALUOP_SLTU;
                selcmps2_imm_o = !reg_form_i;
            end
            F3_XOR:  aluop_o = ALUOP_XOR;
            F3_SRLSRA: begin
                aluop_o = f7_alt ? ALUOP_SRA : ALUOP_SRL;
            end
            F3_OR:   aluop_o = ALUOP_OR;
            default: aluop_o = ALUOP_AND;
        endcase

        // funct7 legality
        if (reg_form_i) begin
            if (!f7_base && !(f7_alt && (fields.funct3 == F3_ADDSUB ||
                                         fields.funct3 == F3_SRLSRA))) begin
                illegal_o = 1'b1;
            end
        end else if (fields.funct3 == F3_SLL) begin
            illegal_o = !f7_base;               // shamt[5] must be clear
        end else if (fields.funct3 == F3_SRLSRA) begin
            illegal_o = !(f7_base || f7_alt);
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_system_decode.sv
// Privileged SYSTEM decode
`timescale 1ns/10ps
`default_nettype none

module rv_system_decode (
    ins_fields_if.dec fields,
    output logic      ecall_o,
    output logic      trap_rtn_o,
    output logic      wfi_o,
    output logic      illegal_o
);

    logic        priv_form;
    logic [11:0] funct12;

    // CSR forms and stray register fields are rejected
    assign priv_form = (fields.funct3 == 3'b000) && (fields.rd == 5'd0) &&
                       (fields.rs1 == 5'd0);
    assign funct12   = fields.ins[31:20];

    always_comb begin
        ecall_o    = 1'b0;
        trap_rtn_o = 1'b0;
        wfi_o      = 1'b0;
        illegal_o  = 1'b0;

        if (!priv_form) begin
            illegal_o = 1'b1;
        end else if (funct12 == 12'h000) begin
            ecall_o = 1'b1;
        end else if (funct12 == 12'h001) begin
            illegal_o = 1'b0;                   // ebreak, no strobe
        end else if (funct12[11:10] == 2'b00 && funct12[7:0] == 8'h02) begin
            trap_rtn_o = 1'b1;                  // uret / sret / mret
        end else if (funct12 == 12'h105) begin
            wfi_o = 1'b1;
        end else begin
            illegal_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_major_decode.sv
// Major opcode decode
`timescale 1ns/10ps
`default_nettype none

module rv_major_decode (
    ins_fields_if.dec                 fields,
    output logic                      illegal_o,
    output logic                      fencei_o,
    output logic                      wfi_o,
    output logic                      jump_o,
    output logic                      ecall_o,
    output logic                      trap_rtn_o,
    output logic                      regd_tgt_o,
    output logic                      regs1_rd_o,
    output logic                      regs2_rd_o,
    output logic                      link_o,
    output logic                      sels1_pc_o,
    output logic                      sels2_imm_o,
    output logic                      selcmps2_imm_o,
    output logic                      conditional_o,
    output rv_decode_pkg::zone_t      zone_o,
    output rv_decode_pkg::aluop_t     aluop_o,
    output rv_decode_pkg::imm_type_t  imm_type_o
);
    import rv_decode_pkg::*;

    aluop_t alu_aluop;
    logic   alu_selcmps2_imm;
    logic   alu_illegal;
    logic   sys_ecall;
    logic   sys_trap_rtn;
    logic   sys_wfi;
    logic   sys_illegal;

    rv_alu_decode u_alu (
        .fields         (fields),
        .reg_form_i     (fields.opcode == OPC_OP),
        .aluop_o        (alu_aluop),
        .selcmps2_imm_o (alu_selcmps2_imm),
        .illegal_o      (alu_illegal)
    );

    rv_system_decode u_sys (
        .fields     (fields),
        .ecall_o    (sys_ecall),
        .trap_rtn_o (sys_trap_rtn),
        .wfi_o      (sys_wfi),
        .illegal_o  (sys_illegal)
    );

    always_comb begin
        illegal_o      = 1'b0;
        fencei_o       = 1'b0;
        wfi_o          = 1'b0;
        jump_o         = 1'b0;
        ecall_o        = 1'b0;
        trap_rtn_o     = 1'b0;
        regd_tgt_o     = 1'b0;
        regs1_rd_o     = 1'b0;
        regs2_rd_o     = 1'b0;
        link_o         = 1'b0;
        sels1_pc_o     = 1'b0;
        sels2_imm_o    = 1'b0;
        selcmps2_imm_o = 1'b0;
        conditional_o  = 1'b0;
        zone_o         = ZONE_NONE;
        aluop_o        = ALUOP_ADD;
        imm_type_o     = IMM_R;

        case (fields.opcode)
            OPC_LUI, OPC_AUIPC: begin
                imm_type_o  = IMM_U;
                zone_o      = ZONE_REGFILE;
                regd_tgt_o  = 1'b1;
                sels2_imm_o = 1'b1;
                if (fields.opcode == OPC_LUI) begin
                    aluop_o = ALUOP_MOV;
                end else begin
                    sels1_pc_o = 1'b1;          // pc + imm
                end
            end
            OPC_JAL, OPC_JALR: begin
                jump_o      = 1'b1;
                zone_o      = ZONE_REGFILE;
                regd_tgt_o  = 1'b1;
                link_o      = 1'b1;
                sels2_imm_o = 1'b1;
                if (fields.opcode == OPC_JAL) begin
                    imm_type_o = IMM_UJ;
                    sels1_pc_o = 1'b1;
                end else begin
                    imm_type_o = IMM_I;
                    regs1_rd_o = 1'b1;
                    illegal_o  = (fields.funct3 != 3'b000);
                end
            end
            OPC_BRANCH: begin
                imm_type_o    = IMM_SB;
                jump_o        = 1'b1;
                regs1_rd_o    = 1'b1;
                regs2_rd_o    = 1'b1;
                sels1_pc_o    = 1'b1;
                sels2_imm_o   = 1'b1;
                conditional_o = 1'b1;
                illegal_o     = (fields.funct3 == 3'b010) || (fields.funct3 == 3'b011);
            end
            OPC_LOAD: begin
                imm_type_o  = IMM_I;
                zone_o      = ZONE_LOADQ;
                regd_tgt_o  = 1'b1;
                regs1_rd_o  = 1'b1;
                sels2_imm_o = 1'b1;
                illegal_o   = (fields.funct3 == 3'b011) || (fields.funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                imm_type_o  = IMM_S;
                zone_o      = ZONE_STOREQ;
                regs1_rd_o  = 1'b1;
                regs2_rd_o  = 1'b1;
                sels2_imm_o = 1'b1;
                illegal_o   = (fields.funct3 >= 3'b011);
            end
            OPC_OPIMM, OPC_OP: begin
                zone_o         = ZONE_REGFILE;
                regd_tgt_o     = 1'b1;
                regs1_rd_o     = 1'b1;
                aluop_o        = alu_aluop;
                selcmps2_imm_o = alu_selcmps2_imm;
                illegal_o      = alu_illegal;
                if (fields.opcode == OPC_OP) begin
                    regs2_rd_o = 1'b1;
                end else begin
                    imm_type_o  = IMM_I;
                    sels2_imm_o = 1'b1;
                end
            end
            OPC_MISCMEM: begin
                imm_type_o = IMM_MISC_MEM;
                fencei_o   = (fields.funct3 == 3'b001);   // plain fence is a no-op
            end
            OPC_SYSTEM: begin
                ecall_o    = sys_ecall;
                trap_rtn_o = sys_trap_rtn;
                wfi_o      = sys_wfi;
                illegal_o  = sys_illegal;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_imm_gen.sv
// Immediate generator
`timescale 1ns/10ps
`default_nettype none

module rv_imm_gen (
    ins_fields_if.dec                fields,
    input  rv_decode_pkg::imm_type_t imm_type_i,
    output rv_decode_pkg::xlen_t     imm_o
);
    import rv_decode_pkg::*;

    ins_t  ins;
    xlen_t sign;

    assign ins  = fields.ins;
    assign sign = {XLEN{ins[31]}};

    always_comb begin
        case (imm_type_i)
            IMM_I:   imm_o = {sign[XLEN-1:11], ins[30:20]};
            IMM_S:   imm_o = {sign[XLEN-1:11], ins[30:25], ins[11:7]};
            IMM_SB:  imm_o = {sign[XLEN-1:12], ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_U:   imm_o = {ins[31:12], 12'b0};
            IMM_UJ:  imm_o = {sign[XLEN-1:20], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: imm_o = '0;               // R form and misc-mem carry none
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_decoder_top.sv
// Registered RV32I decode stage
`timescale 1ns/10ps
`default_nettype none

module rv_decoder_top (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       ins_valid_i,
    input  wire rv_decode_pkg::ins_t  ins_i,
    output logic                      dec_valid_o,
    output logic                      ins_err_o,
    output logic                      fencei_o,
    output logic                      wfi_o,
    output logic                      jump_o,
    output logic                      ecall_o,
    output logic                      trap_rtn_o,
    output logic                      regd_tgt_o,
    output logic                      regs1_rd_o,
    output logic                      regs2_rd_o,
    output logic                      link_o,
    output logic                      sels1_pc_o,
    output logic                      sels2_imm_o,
    output logic                      selcmps2_imm_o,
    output logic                      conditional_o,
    output rv_decode_pkg::zone_t      zone_o,
    output rv_decode_pkg::reg_addr_t  regd_addr_o,
    output rv_decode_pkg::reg_addr_t  regs1_addr_o,
    output rv_decode_pkg::reg_addr_t  regs2_addr_o,
    output rv_decode_pkg::xlen_t      imm_o,
    output rv_decode_pkg::aluop_t     aluop_o,
    output rv_decode_pkg::funct3_t    funct3_o
);
    import rv_decode_pkg::*;

    localparam int NSTB = 11;

    ins_fields_if u_fields ();

    logic [NSTB-1:0] d_stb;      // err fencei wfi jump ecall trap_rtn tgt rs1 rs2 link cond
    logic            d_sels1_pc;
    logic            d_sels2_imm;
    logic            d_selcmps2_imm;
    zone_t           d_zone;
    aluop_t          d_aluop;
    imm_type_t       d_imm_type;
    xlen_t           d_imm;

    //----------------------------------------------------------------------
    // field slicing
    //----------------------------------------------------------------------
    assign u_fields.opcode = ins_i[6:0];
    assign u_fields.funct3 = ins_i[14:12];
    assign u_fields.funct7 = ins_i[31:25];
    assign u_fields.rd     = ins_i[11:7];
    assign u_fields.rs1    = ins_i[19:15];
    assign u_fields.ins    = ins_i;

    rv_major_decode u_major (
        .fields         (u_fields.dec),
        .illegal_o      (d_stb[10]),
        .fencei_o       (d_stb[9]),
        .wfi_o          (d_stb[8]),
        .jump_o         (d_stb[7]),
        .ecall_o        (d_stb[6]),
        .trap_rtn_o     (d_stb[5]),
        .regd_tgt_o     (d_stb[4]),
        .regs1_rd_o     (d_stb[3]),
        .regs2_rd_o     (d_stb[2]),
        .link_o         (d_stb[1]),
        .sels1_pc_o     (d_sels1_pc),
        .sels2_imm_o    (d_sels2_imm),
        .selcmps2_imm_o (d_selcmps2_imm),
        .conditional_o  (d_stb[0]),
        .zone_o         (d_zone),
        .aluop_o        (d_aluop),
        .imm_type_o     (d_imm_type)
    );

    rv_imm_gen u_imm (
        .fields     (u_fields.dec),
        .imm_type_i (d_imm_type),
        .imm_o      (d_imm)
    );

    //----------------------------------------------------------------------
    // output register
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            zone_o      <= ZONE_NONE;
            {ins_err_o, fencei_o, wfi_o, jump_o, ecall_o, trap_rtn_o, regd_tgt_o,
             regs1_rd_o, regs2_rd_o, link_o, conditional_o} <= '0;
        end else begin
            dec_valid_o <= ins_valid_i;
            zone_o      <= ins_valid_i ? d_zone : ZONE_NONE;
            {ins_err_o, fencei_o, wfi_o, jump_o, ecall_o, trap_rtn_o, regd_tgt_o,
             regs1_rd_o, regs2_rd_o, link_o, conditional_o} <= ins_valid_i ? d_stb : '0;
        end
    end

    // payload holds across idle cycles
    always_ff @(posedge clk_i) begin
        if (ins_valid_i) begin
            regd_addr_o    <= ins_i[11:7];
            regs1_addr_o   <= ins_i[19:15];
            regs2_addr_o   <= ins_i[24:20];
            funct3_o       <= ins_i[14:12];
            imm_o          <= d_imm;
            aluop_o        <= d_aluop;
            sels1_pc_o     <= d_sels1_pc;
            sels2_imm_o    <= d_sels2_imm;
            selcmps2_imm_o <= d_selcmps2_imm;
        end
    end

endmodule

`default_nettype wire

//--- bench/decoder_chk.sv
// Decode stage output assertions
`timescale 1ns/10ps
`default_nettype none

module decoder_chk (
    input wire        clk_i,
    input wire        rst_n_i,
    input wire        ins_valid_i,
    input wire        dec_valid_i,
    input wire [10:0] stb_i         // err fencei wfi jump ecall trap_rtn tgt rs1 rs2 link cond
);

    logic ins_err;
    logic fencei;
    logic wfi;
    logic ecall;
    logic trap_rtn;

    assign {ins_err, fencei, wfi} = stb_i[10:8];
    assign ecall                  = stb_i[6];
    assign trap_rtn               = stb_i[5];

    a_valid_delay: assert property (@(posedge clk_i)
        rst_n_i |=> dec_valid_i == $past(ins_valid_i))
        else $error("dec_valid_o did not follow ins_valid_i");

    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !dec_valid_i |-> stb_i == '0)
        else $error("strobe high while dec_valid_o is low");

    a_one_system: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ecall, trap_rtn, wfi}))
        else $error("more than one system strobe high");

    a_err_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ins_err |-> !(ecall || trap_rtn || wfi || fencei))
        else $error("system or fence strobe high on an illegal word");

endmodule

bind rv_decoder_top decoder_chk u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ins_valid_i (ins_valid_i),
    .dec_valid_i (dec_valid_o),
    .stb_i       ({ins_err_o, fencei_o, wfi_o, jump_o, ecall_o, trap_rtn_o, regd_tgt_o,
                   regs1_rd_o, regs2_rd_o, link_o, conditional_o})
);

`default_nettype wire

//--- bench/tb_decoder.sv
// Decode stage testbench
`timescale 1ns/10ps
`default_nettype none

module tb_decoder;
    import rv_decode_pkg::*;

    localparam int NCOL  = 6;
    localparam int DEPTH = 512;
    localparam int SEED  = 32'hbe34;

    logic      clk_i;
    logic      rst_n_i;
    logic      ins_valid_i;
    ins_t      ins_i;
    logic      dec_valid_o, ins_err_o, fencei_o, wfi_o, jump_o, ecall_o, trap_rtn_o;
    logic      regd_tgt_o, regs1_rd_o, regs2_rd_o, link_o, sels1_pc_o, sels2_imm_o;
    logic      selcmps2_imm_o, conditional_o;
    zone_t     zone_o;
    reg_addr_t regd_addr_o, regs1_addr_o, regs2_addr_o;
    xlen_t     imm_o;
    aluop_t    aluop_o;
    funct3_t   funct3_o;

    logic [31:0] stim [0:DEPTH-1];      // word 0 is the vector count
    int          nvec;
    int          checks;
    bit          loaded;
    int          errs[$]  = '{0, 0, 0, 0, 0, 0};
    string       names[$] = '{"reset state", "alu decode", "major opcodes",
                              "system and fence", "pipeline timing", "field passthrough"};
    logic [10:0] quiet_stb;
    logic [12:0] got_stb;

    // strobes that clear on idle cycles
    assign quiet_stb = {ins_err_o, fencei_o, wfi_o, jump_o, ecall_o, trap_rtn_o, regd_tgt_o,
                        regs1_rd_o, regs2_rd_o, link_o, conditional_o};
    // same packing as the stimulus file
    assign got_stb = {fencei_o, wfi_o, jump_o, ecall_o, trap_rtn_o, regd_tgt_o, regs1_rd_o,
                      regs2_rd_o, link_o, sels1_pc_o, sels2_imm_o, selcmps2_imm_o,
                      conditional_o};

    rv_decoder_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (40 * nvec + 100) @(posedge clk_i);
        $display("timeout: decode stream did not finish in %0d cycles", 40 * nvec + 100);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] stim_word(input int vec, input int col);
        logic [8:0] addr;
        addr = 9'(1 + NCOL * vec + col);
        return stim[addr];
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input int test);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
            errs[test-1]++;
        end
    endtask

    task automatic expect_quiet(input int test);
        compare_field("dec_valid_o", 32'(dec_valid_o), 32'd0, test);
        compare_field("strobes", 32'(quiet_stb), 32'd0, test);
        compare_field("zone_o", 32'(zone_o), 32'(ZONE_NONE), test);
    endtask

    task automatic verify_vector(input int vec);
        ins_t w;
        int   grp;
        w = stim_word(vec, 0);
        case (w[6:0])
            OPC_OP, OPC_OPIMM:       grp = 2;
            OPC_SYSTEM, OPC_MISCMEM: grp = 4;
            default:                 grp = 3;
        endcase
        compare_field("dec_valid_o", 32'(dec_valid_o), 32'd1, 5);
        compare_field("ins_err_o", 32'(ins_err_o), stim_word(vec, 1), grp);
        compare_field("aluop_o", 32'(aluop_o), stim_word(vec, 2), grp);
        compare_field("zone_o", 32'(zone_o), stim_word(vec, 3), grp);
        compare_field("imm_o", imm_o, stim_word(vec, 4), grp);
        compare_field("strobes", 32'(got_stb), stim_word(vec, 5), grp);
        compare_field("regd_addr_o", 32'(regd_addr_o), 32'(w[11:7]), 6);
        compare_field("regs1_addr_o", 32'(regs1_addr_o), 32'(w[19:15]), 6);
        compare_field("regs2_addr_o", 32'(regs2_addr_o), 32'(w[24:20]), 6);
        compare_field("funct3_o", 32'(funct3_o), 32'(w[14:12]), 6);
    endtask

    task automatic report_test(input int test);
        if (errs[test-1] == 0) begin
            $display("test %0d %s: pass", test, names[test-1]);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", test, names[test-1], errs[test-1]);
        end
    endtask

    initial begin
        int prev;
        int cur;
        int idx;
        int fails;
        int t;
        bit done;
        void'($urandom(SEED));
        rst_n_i     = 1'b0;
        ins_valid_i = 1'b0;
        ins_i       = '0;
        checks      = 0;
        $readmemh("bench/decoder_stimulus.txt", stim);
        nvec   = stim[0];
        loaded = 1'b1;

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        expect_quiet(1);
        report_test(1);

        //------------------------------------------------------------------
        // stream, result checked one cycle after sampling
        //------------------------------------------------------------------
        prev = -1;
        idx  = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            cur = -1;
            if (idx < nvec && ($urandom % 4) != 0) begin
                cur = idx;
                idx++;
                ins_i <= stim_word(cur, 0);
            end
            ins_valid_i <= (cur >= 0);
            @(negedge clk_i);
            if (prev >= 0) begin
                verify_vector(prev);
            end else begin
                expect_quiet(5);
            end
            done = (idx >= nvec) && (cur < 0);
            prev = cur;
        end

        for (t = 2; t <= 6; t++) begin
            report_test(t);
        end
        fails = errs.sum();
        $display("%0d checks, %0d errors", checks, fails);
        if (fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/decoder_stimulus.txt
// columns: word ins_err aluop zone imm strobes, first value is the vector count
// strobes: fencei wfi jump ecall trap_rtn regd_tgt rs1 rs2 link sels1_pc sels2_imm cmps2 cond
1a
fff00093 0 0 1 ffffffff 00c4
402081b3 0 1 1 00000000 00e0
407352b3 0 7 1 00000000 00e0
023100b3 1 0 1 00000000 00e0
0052a213 0 3 1 00000005 00c6
4030d093 0 7 1 00000403 00c4
40111113 1 2 1 00000401 00c4
12345537 0 a 1 12345000 0084
fffff117 0 0 1 fffff000 008c
ffdff0ef 0 0 1 fffffffc 049c
00008067 0 0 1 00000000 04d4
00009067 1 0 1 00000000 04d4
fe208ce3 0 0 0 fffffff8 046d
fe20ace3 1 0 0 fffffff8 046d
ff012283 0 0 2 fffffff0 00c4
ff013283 1 0 2 fffffff0 00c4
0063a623 0 0 3 0000000c 0064
0063b623 1 0 3 0000000c 0064
00000073 0 0 0 00000000 0200
00100073 0 0 0 00000000 0000
30200073 0 0 0 00000000 0100
10500073 0 0 0 00000000 0800
300110f3 1 0 0 00000000 0000
000000f3 1 0 0 00000000 0000
0000100f 0 0 0 00000000 1000
0000007f 1 0 0 00000000 0000

//--- files.f
rtl/rv_decode_pkg.sv
rtl/ins_fields_if.sv
rtl/rv_alu_decode.sv
rtl/rv_system_decode.sv
rtl/rv_major_decode.sv
rtl/rv_imm_gen.sv
rtl/rv_decoder_top.sv
bench/decoder_chk.sv
bench/tb_decoder.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_decoder
FLIST     := files.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))
PASS_MSG  := Everything OK

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
